/* verilog.f */
axis_rl_pkg.sv
axis_skid_reg.sv
axis_rate_limit.sv
axis_stream_stats.sv
axis_rate_limit_top.sv
tb_axis_rate_limit_sva.sv
tb_axis_rate_limit.sv

/* Bender.yml */
package:
  name: axis_rate_limit

sources:
  - axis_rl_pkg.sv
  - axis_skid_reg.sv
  - axis_rate_limit.sv
  - axis_stream_stats.sv
  - axis_rate_limit_top.sv
  - target: test
    files:
      - tb_axis_rate_limit_sva.sv
      - tb_axis_rate_limit.sv

/* tb_axis_rate_limit.sv */
/*
 * Directed testbench for the rate limited stream top.
 * Inputs change on the falling edge, outputs are sampled on the rising edge.
 * cfg only changes while the stream is idle.
 */
`timescale 1ns/1ps

module tb_axis_rate_limit;
    import axis_rl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_DENOM    = 8;
    // full rate, three fractional runs, frames, back-pressure, stats
    localparam int TOTAL_BEATS  = 64 + 3 * 400 + 30 + 300 + 24;
    localparam int TIMEOUT_NS   = TOTAL_BEATS * MAX_DENOM * CLK_PERIOD * 2
                                  + 4000 * CLK_PERIOD;

    logic          clk;
    logic          rst;
    axis_beat_t    in_beat;
    logic          in_valid;
    logic          in_ready;
    axis_beat_t    out_beat;
    logic          out_valid;
    logic          out_ready;
    rate_cfg_t     cfg;
    logic          stats_clear;
    stream_stats_t stats;

    logic [31:0]   rng_state;
    axis_beat_t    ref_q[$];
    // cycle number of each output transfer in the current run
    int            out_cycle[$];
    int            cyc;
    int            error_count;
    int            check_count;
    stream_stats_t exp_stats;

    axis_rate_limit_top DUT (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .cfg         (cfg),
        .stats_clear (stats_clear),
        .stats       (stats)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // rising edge count, times the output transfers
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // frame_len 0 gives a random last bit
    function automatic axis_beat_t make_beat(input int idx, input int frame_len);
        axis_beat_t  b;
        logic [31:0] r;
        b.data = {lcg_next(), lcg_next()};
        r = lcg_next();
        b.keep = (r[7:0] == 8'h00) ? 8'hff : r[7:0];
        b.user = r[8];
        if (frame_len > 0) begin
            b.last = ((idx + 1) % frame_len) == 0;
        end else begin
            b.last = r[9];
        end
        return b;
    endfunction

    task automatic compare_beat(input axis_beat_t got, input axis_beat_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: beat data=%h keep=%h last=%b user=%b, expected %h %h %b %b",
                     $time, got.data, got.keep, got.last, got.user,
                     exp.data, exp.keep, exp.last, exp.user);
        end
    endtask

    task automatic compare_stats(input stream_stats_t got, input stream_stats_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: stats beats=%0d frames=%0d bytes=%0d, expected %0d %0d %0d",
                     $time, got.beats, got.frames, got.bytes,
                     exp.beats, exp.frames, exp.bytes);
        end
    endtask

    task automatic check_cond(input logic ok, input string msg);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    task automatic drive_beats(input int n, input int gap_pct, input int frame_len);
        axis_beat_t b;
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            b = make_beat(i, frame_len);
            ref_q.push_back(b);
            exp_stats.beats  = exp_stats.beats + 1;
            exp_stats.frames = exp_stats.frames + b.last;
            exp_stats.bytes  = exp_stats.bytes + $countones(b.keep);
            // random idle cycles before the beat
            while (gap_pct > 0 && (lcg_next() % 100) < gap_pct) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_beat  = b;
            in_valid = 1'b1;
            // in_ready read here is the value at the edge
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_beats(input int n, input int ready_pct);
        int   got;
        logic rdy;
        got = 0;
        while (got < n) begin
            // sink ready for the coming cycle, drawn while the driver is idle
            rdy = (ready_pct >= 100) ? 1'b1 : ((lcg_next() % 100) < ready_pct);
            @(negedge clk);
            out_ready = rdy;
            @(posedge clk);
            if (out_valid && out_ready) begin
                if (ref_q.size() == 0) begin
                    error_count++;
                    $display("output beat at %0t ns with nothing expected", $time);
                end else begin
                    compare_beat(out_beat, ref_q.pop_front());
                end
                out_cycle.push_back(cyc);
                got++;
            end
        end
    endtask

    task automatic stream_run(input int n, input int gap_pct, input int ready_pct,
                              input int frame_len);
        out_cycle.delete();
        fork
            drive_beats(n, gap_pct, frame_len);
            collect_beats(n, ready_pct);
        join
        @(negedge clk);
        out_ready = 1'b1;
        // every accepted beat has left, so the output register is empty
        check_cond(!out_valid, "output still valid after the last expected beat");
    endtask

    // change the rate while idle and let the accumulator settle
    task automatic set_rate(input int num, input int denom, input logic by_frame);
        @(negedge clk);
        cfg.num      = 8'(num);
        cfg.denom    = 8'(denom);
        cfg.by_frame = by_frame;
        repeat (2 * MAX_DENOM + 4) @(negedge clk);
    endtask

    task automatic test_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_cond(!in_ready && !out_valid, "handshake outputs high in reset");
            compare_stats(stats, '0);
        end
        rst = 1'b0;
        // first edge out of reset, nothing offered yet
        @(negedge clk);
        check_cond(!out_valid, "output valid right after reset");
        compare_stats(stats, '0);
        $display("test reset finished, %0d errors so far", error_count);
    endtask

    task automatic test_full_rate();
        set_rate(4, 4, 1'b0);
        stream_run(64, 0, 100, 0);
        for (int i = 1; i < 64; i++) begin
            check_cond(out_cycle[i] == out_cycle[0] + i, "gap in full rate stream");
        end
        $display("test full_rate finished, %0d errors so far", error_count);
    endtask

    task automatic test_fractional();
        int nums[3];
        int dens[3];
        int w;
        int diff;
        nums = '{3, 1, 5};
        dens = '{4, 8, 7};
        for (int k = 0; k < 3; k++) begin
            set_rate(nums[k], dens[k], 1'b0);
            stream_run(400, 0, 100, 0);
            // 300 transfers in the window between beat 50 and beat 350
            w = out_cycle[350] - out_cycle[50];
            diff = 300 * dens[k] - w * nums[k];
            if (diff < 0) diff = -diff;
            check_cond(diff <= 2 * dens[k], "fractional rate outside tolerance");
        end
        $display("test fractional finished, %0d errors so far", error_count);
    endtask

    task automatic test_frame_mode();
        int w;
        int diff;
        set_rate(1, 4, 1'b1);
        stream_run(30, 0, 100, 3);
        for (int f = 0; f < 10; f++) begin
            for (int j = 1; j < 3; j++) begin
                check_cond(out_cycle[f * 3 + j] == out_cycle[f * 3] + j, "frame split by pause");
            end
        end
        // whole frames 2 to 8, measured start to start
        w = out_cycle[27] - out_cycle[6];
        diff = 21 * 4 - w;
        if (diff < 0) diff = -diff;
        check_cond(diff <= 2 * 4, "frame mode rate outside tolerance");
        $display("test frame_mode finished, %0d errors so far", error_count);
    endtask

    task automatic test_backpressure();
        set_rate(4, 4, 1'b0);
        stream_run(150, 30, 50, 0);
        set_rate(2, 3, 1'b0);
        stream_run(150, 20, 60, 0);
        $display("test backpressure finished, %0d errors so far", error_count);
    endtask

    task automatic test_stats();
        set_rate(4, 4, 1'b0);
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        exp_stats = '0;
        compare_stats(stats, '0);
        stream_run(24, 20, 70, 4);
        repeat (2) @(negedge clk);
        compare_stats(stats, exp_stats);
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        compare_stats(stats, '0);
        $display("test stats finished, %0d errors so far", error_count);
    endtask

    initial begin
        rng_state   = 32'h4c19_111b;
        cyc         = 0;
        error_count = 0;
        check_count = 0;
        exp_stats   = '0;
        rst         = 1'b1;
        in_beat     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        cfg         = '{num: 8'd4, denom: 8'd4, by_frame: 1'b0};
        stats_clear = 1'b0;

        test_reset();
        test_full_rate();
        test_fractional();
        test_frame_mode();
        test_backpressure();
        test_stats();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_axis_rate_limit_sva.sv */
/*
 * Checker bound to the rate limited stream top.
 * The in_ready gap check only runs outside frame mode.
 * A long frame can hold the limiter off for longer than the window.
 */
`timescale 1ns/1ps

module tb_axis_rate_limit_sva
    import axis_rl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       in_ready,
    input axis_beat_t out_beat,
    input logic       out_valid,
    input logic       out_ready,
    input rate_cfg_t  cfg
);

    // consecutive cycles with in_ready low while the sink is ready
    int unsigned low_run;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_run <= 0;
        end else if (!in_ready && out_ready && !cfg.by_frame) begin
            low_run <= low_run + 1;
        end else begin
            low_run <= 0;
        end
    end

    // both handshake outputs held low in reset
    reset_quiet: assert property (@(posedge clk) rst |-> (!out_valid && !in_ready))
        else $error("out_valid or in_ready high during reset");

    // a stalled beat must not change
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("output beat changed while stalled");

    // pause is bounded by the averaging window
    pause_bound: assert property (@(posedge clk) disable iff (rst)
        low_run <= cfg.denom + 2)
        else $error("in_ready low for too long with sink ready");

endmodule

bind axis_rate_limit_top tb_axis_rate_limit_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .cfg       (cfg)
);

/* axis_rate_limit_top.sv */
/*
 * Rate limited stream with output statistics.
 * cfg is a plain level input and must stay stable during traffic.
 * stats_clear is a single cycle pulse.
 * The statistics count what leaves on the output port.
 */
`timescale 1ns/1ps

module axis_rate_limit_top
    import axis_rl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    // input stream
    input  axis_beat_t    in_beat,
    input  logic          in_valid,
    output logic          in_ready,
    // output stream
    output axis_beat_t    out_beat,
    output logic          out_valid,
    input  logic          out_ready,
    // rate configuration
    input  rate_cfg_t     cfg,
    // statistics
    input  logic          stats_clear,
    output stream_stats_t stats
);

    // limiter owns the output port through its output register
    axis_rate_limit u_limit (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // taps the output handshake as seen at the port
    axis_stream_stats u_stats (
        .clk   (clk),
        .rst   (rst),
        .beat  (out_beat),
        .valid (out_valid),
        .ready (out_ready),
        .clear (stats_clear),
        .stats (stats)
    );

endmodule

/* axis_stream_stats.sv */
/*
 * Beat, frame and byte counters on a valid/ready stream.
 * Passive observer that drives nothing on the stream.
 * Counters wrap at full scale, and clear beats a same cycle transfer.
 * Values appear one cycle after the counted transfer.
 */
`timescale 1ns/1ps

module axis_stream_stats
    import axis_rl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  axis_beat_t    beat,
    input  logic          valid,
    input  logic          ready,
    input  logic          clear,
    output stream_stats_t stats
);

    // bytes carried by one beat, count of set keep bits
    function automatic logic [CNT_W-1:0] keep_bytes(input logic [KEEP_W-1:0] keep);
        logic [CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + CNT_W'(keep[i]);
        end
        return n;
    endfunction

    stream_stats_t stats_reg;
    logic          xfer;
    logic [CNT_W-1:0] beat_bytes;

    // a beat is counted only when it actually moves
    assign xfer = valid & ready;

    assign beat_bytes = keep_bytes(beat.keep);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stats_reg <= '0;
        end else if (clear) begin
            // software clear, wins over a transfer
            stats_reg <= '0;
        end else if (xfer) begin
            stats_reg.beats  <= stats_reg.beats + CNT_W'(1);
            // one frame per last beat
            stats_reg.frames <= stats_reg.frames + CNT_W'(beat.last);
            stats_reg.bytes  <= stats_reg.bytes + beat_bytes;
        end
    end

    assign stats = stats_reg;

endmodule

/* axis_rate_limit.sv */
/*
 * Credit based rate limiter, num beats per denom cycles on average.
 * cfg is a level input and must stay stable while traffic flows.
 * In frame mode a frame is never split by a pause, so frames longer
 * than the window overshoot the rate until credit is paid back.
 * in_ready is registered and may drop while in_valid is high.
 */
`timescale 1ns/1ps

module axis_rate_limit
    import axis_rl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rate_cfg_t  cfg,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    // credit debt, drains by num per cycle
    logic [ACC_W-1:0] acc_reg;
    logic [ACC_W-1:0] acc_next;
    // rate fields widened to accumulator width
    logic [ACC_W-1:0] num_ext;
    logic [ACC_W-1:0] step;

    // high while a frame has started but its last beat is still due
    logic frame_reg;
    logic frame_next;

    logic pause;
    logic accept;
    logic in_ready_reg;
    logic in_ready_next;

    // early ready from the output register
    logic skid_ready_early;

    assign num_ext = ACC_W'(cfg.num);
    // cost of one beat over what one cycle pays back
    // denom >= num keeps this non negative
    assign step = ACC_W'(cfg.denom) - num_ext;

    assign accept = in_valid & in_ready_reg;

    always_comb begin
        acc_next   = acc_reg;
        frame_next = frame_reg;
        pause      = 1'b0;

        // pay back one cycle worth of credit
        if (acc_reg >= num_ext) begin
            acc_next = acc_reg - num_ext;
        end

        // accepted beat replaces the payback with the net beat cost
        if (accept) begin
            frame_next = ~in_beat.last;
            acc_next   = acc_reg + step;
        end

        // still in debt after this cycle
        if (acc_next >= num_ext) begin
            if (cfg.by_frame) begin
                // hold off until the frame boundary
                pause = ~frame_next;
            end else begin
                pause = 1'b1;
            end
        end
    end

    // take effect next cycle, skid temp entry covers the gap
    assign in_ready_next = skid_ready_early & ~pause;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_reg      <= '0;
            frame_reg    <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            acc_reg      <= acc_next;
            frame_reg    <= frame_next;
            in_ready_reg <= in_ready_next;
        end
    end

    assign in_ready = in_ready_reg;

    // registered output stage
    // only accepted beats are presented as valid
    axis_skid_reg #(
        .T (axis_beat_t)
    ) u_out_reg (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_beat),
        .in_valid    (accept),
        .ready_early (skid_ready_early),
        .out_data    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

/* axis_skid_reg.sv */
/*
 * Two-entry output register, main plus temp, for any payload type T.
 * in_valid must only be high while the previous ready_early was high.
 * Output is fully registered, and ready_early is a combinational term
 * that the source registers and presents one cycle late.
 */
`timescale 1ns/1ps

module axis_skid_reg
    import axis_rl_pkg::*;
#(
    parameter type T = axis_beat_t
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic ready_early,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    // main entry drives the output port
    T     main_data;
    logic main_valid;
    // temp entry catches the beat that lands during the ready delay
    T     temp_data;
    logic temp_valid;
    // ready_early one cycle late, the source sees the same value
    logic ready_reg;

    logic load_main;
    logic load_temp;
    logic drain;

    // ready next cycle if the sink takes a beat now,
    // or both entries are empty,
    // or temp is empty and nothing arrives to fill main
    assign ready_early = out_ready | (~temp_valid & ~main_valid) | (~temp_valid & ~in_valid);

    // input side open, main free or emptying this cycle
    assign load_main = ready_reg & (out_ready | ~main_valid);
    // input side open but main stalled, park the beat in temp
    assign load_temp = ready_reg & ~out_ready & main_valid;
    // input side closed and sink ready, move temp forward
    assign drain = ~ready_reg & out_ready;

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            main_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_main) begin
                main_valid <= in_valid;
            end else if (drain) begin
                main_valid <= temp_valid;
                temp_valid <= 1'b0;
            end
            if (load_temp) begin
                temp_valid <= in_valid;
            end
        end
    end

    // payload registers follow the same load decisions
    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= in_data;
        end else if (drain) begin
            main_data <= temp_data;
        end
        if (load_temp) begin
            temp_data <= in_data;
        end
    end

    assign out_data  = main_data;
    assign out_valid = main_valid;

endmodule

/* axis_rl_pkg.sv */
/*
 * Shared widths and payload types for the stream rate limiter.
 * cfg.num must be above zero and cfg.denom must not be below cfg.num.
 * The hardware does not check either condition.
 * One keep bit covers one data byte, and the byte counts rely on that.
 */
package axis_rl_pkg;

    // width of the data bus of one beat
    localparam int DATA_W = 64;

    // one keep bit per data byte
    localparam int KEEP_W = DATA_W / 8;

    // credit accumulator width
    // rate fields are 8 bit, so this leaves plenty of headroom
    localparam int ACC_W = 24;

    // width of each statistics counter, wraps at full scale
    localparam int CNT_W = 32;

    // one beat of the packet stream, 74 bits
    // field order is msb first: data, keep, last, user
    typedef struct packed {
        // payload bytes, byte 0 in the low bits
        logic [DATA_W-1:0] data;
        // byte enables for data
        logic [KEEP_W-1:0] keep;
        // marks the final beat of a frame
        logic              last;
        // sideband bit, passed along untouched
        logic              user;
    } axis_beat_t;

    // limiter configuration, 17 bits, held stable by the user
    typedef struct packed {
        // beats allowed per denom cycles on average
        logic [7:0] num;
        // length of the averaging window in cycles
        logic [7:0] denom;
        // only pause between frames when set
        logic       by_frame;
    } rate_cfg_t;

    // output statistics, 96 bits
    typedef struct packed {
        // transferred beats
        logic [CNT_W-1:0] beats;
        // transferred beats with last set
        logic [CNT_W-1:0] frames;
        // sum of set keep bits over all transfers
        logic [CNT_W-1:0] bytes;
    } stream_stats_t;

endpackage
